// ==== logic/decode_pkg.sv ====
package decode_pkg;

	localparam int XLEN = 64; // Register width

	// Base opcodes of RV64I
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;

	// Fetch packet, 97 bits
	typedef struct packed {
		logic [31:0]     instr;  // Only low half counts for RVC
		logic [XLEN-1:0] pc;
		logic            is_rvc;
	} fetch_pkt_t;

	typedef enum logic [3:0] {
		OP_ALU, OP_ALU_IMM, OP_LOAD, OP_STORE, OP_BRANCH,
		OP_JAL, OP_JALR, OP_LUI, OP_AUIPC, OP_ILLEGAL
	} op_class_t;

	// Low three bits follow funct3, bit 3 is funct7[5] for ALU ops
	// Loads and stores put their funct3 here as well
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,  ALU_SLL  = 4'd1,  ALU_SLT  = 4'd2,  ALU_SLTU = 4'd3,
		ALU_XOR  = 4'd4,  ALU_SRL  = 4'd5,  ALU_OR   = 4'd6,  ALU_AND  = 4'd7,
		ALU_SUB  = 4'd8,  ALU_SRA  = 4'd13,
		ALU_BEQ  = 4'd9,  ALU_BNE  = 4'd10, ALU_BLT  = 4'd11, ALU_BGE  = 4'd12,
		ALU_BLTU = 4'd14, ALU_BGEU = 4'd15
	} alu_fn_t;

	// Micro-instruction handed to issue
	typedef struct packed {
		logic [XLEN-1:0] pc;
		op_class_t       op;
		alu_fn_t         fn;
		logic [4:0]      rd;      // Zero when not written
		logic [4:0]      rs1;     // Zero when not read
		logic [4:0]      rs2;
		logic [XLEN-1:0] imm;     // Sign-extended
		logic            is_word; // OP-32 / OP-IMM-32 forms
		logic            is_rvc;
	} micro_instr_t;

endpackage

// ==== logic/bypass_fifo.sv ====
`timescale 1ns/1ps

module bypass_fifo #(
	parameter type payload_t = logic
) (
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     ready_o, // Upstream may send

	output logic     valid_o,
	output payload_t data_o,
	input  logic     ready_i, // Downstream takes

	input  logic     flush_i,
	input  logic     CLK,
	input  logic     reset_i
);

	logic     full;     // Holding a stored entry
	payload_t buf_data; // Stored payload

	// Empty buffer passes input straight through
	assign valid_o = full | valid_i;
	assign data_o  = full ? buf_data : data_i;
	assign ready_o = ~full; // Refuse input while holding

	always_ff @(posedge CLK) begin
		if (reset_i | flush_i) begin
			full <= 1'b0;
		end else if (~full & valid_i & ~ready_i) begin
			full <= 1'b1; // Downstream stalled, keep it
		end else if (full & ready_i) begin
			full <= 1'b0; // Stored entry drained
		end
	end

	// Capture only when the pass-through is refused
	always_ff @(posedge CLK) begin
		if (~full & valid_i & ~ready_i) begin
			buf_data <= data_i;
		end
	end

endmodule

// ==== logic/rvc_decoder.sv ====
`timescale 1ns/1ps

module rvc_decoder import decode_pkg::*; (
	input  logic [15:0]     instr_i,
	input  logic [XLEN-1:0] pc_i,
	output micro_instr_t    micro_o
);

	logic [2:0]      funct3;
	logic [4:0]      rd_full;  // Full register field [11:7]
	logic [4:0]      rs2_full; // Full register field [6:2]
	logic [4:0]      rd_p;     // Compressed field [4:2], x8..x15
	logic [4:0]      rs1_p;    // Compressed field [9:7], x8..x15
	logic [XLEN-1:0] imm_ci;   // 6-bit signed
	logic [XLEN-1:0] imm_lw;   // Word offset, unsigned
	logic [XLEN-1:0] imm_cj;   // Jump offset
	logic [XLEN-1:0] imm_cb;   // Branch offset
	logic            illegal;

	assign funct3   = instr_i[15:13];
	assign rd_full  = instr_i[11:7];
	assign rs2_full = instr_i[6:2];
	assign rd_p     = {2'b01, instr_i[4:2]};
	assign rs1_p    = {2'b01, instr_i[9:7]};

	assign imm_ci = {{58{instr_i[12]}}, instr_i[12], instr_i[6:2]};
	assign imm_lw = {57'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};
	assign imm_cj = {{52{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
		instr_i[7], instr_i[2], instr_i[11], instr_i[5:3], 1'b0};
	assign imm_cb = {{55{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
		instr_i[11:10], instr_i[4:3], 1'b0};

	always_comb begin
		illegal        = 1'b0;
		micro_o        = '0;
		micro_o.pc     = pc_i;
		micro_o.op     = OP_ALU_IMM;
		micro_o.fn     = ALU_ADD;
		micro_o.is_rvc = 1'b1;
		case ({instr_i[1:0], funct3}) // Quadrant and funct3
			5'b00_010: begin // C.LW
				micro_o.op  = OP_LOAD;
				micro_o.fn  = alu_fn_t'(4'b0010);
				micro_o.rd  = rd_p;
				micro_o.rs1 = rs1_p;
				micro_o.imm = imm_lw;
			end
			5'b00_110: begin // C.SW
				micro_o.op  = OP_STORE;
				micro_o.fn  = alu_fn_t'(4'b0010);
				micro_o.rs1 = rs1_p;
				micro_o.rs2 = rd_p;
				micro_o.imm = imm_lw;
			end
			5'b01_000, 5'b01_001: begin // C.ADDI, C.ADDIW
				micro_o.rd      = rd_full;
				micro_o.rs1     = rd_full;
				micro_o.imm     = imm_ci;
				micro_o.is_word = funct3[0];
				illegal         = funct3[0] & (rd_full == 5'd0); // ADDIW x0 reserved
			end
			5'b01_010: begin // C.LI, addi rd, x0, imm
				micro_o.rd  = rd_full;
				micro_o.imm = imm_ci;
			end
			5'b01_101: begin // C.J
				micro_o.op  = OP_JAL;
				micro_o.imm = imm_cj;
			end
			5'b01_110, 5'b01_111: begin // C.BEQZ, C.BNEZ against x0
				micro_o.op  = OP_BRANCH;
				micro_o.fn  = funct3[0] ? ALU_BNE : ALU_BEQ;
				micro_o.rs1 = rs1_p;
				micro_o.imm = imm_cb;
			end
			5'b10_100: begin
				if (~instr_i[12] & (rs2_full == 5'd0)) begin // C.JR
					micro_o.op  = OP_JALR;
					micro_o.rs1 = rd_full;
					illegal     = (rd_full == 5'd0);
				end else if (rs2_full != 5'd0) begin // C.MV or C.ADD
					micro_o.op  = OP_ALU;
					micro_o.rd  = rd_full;
					micro_o.rs1 = instr_i[12] ? rd_full : 5'd0;
					micro_o.rs2 = rs2_full;
				end else begin
					illegal = 1'b1; // C.EBREAK, C.JALR
				end
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			micro_o        = '0;
			micro_o.pc     = pc_i;
			micro_o.op     = OP_ILLEGAL;
			micro_o.fn     = ALU_ADD;
			micro_o.is_rvc = 1'b1;
		end
	end

endmodule

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import decode_pkg::*; (
	input  logic [31:0]     instr_i,
	input  logic [XLEN-1:0] pc_i,
	output micro_instr_t    micro_o
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic            illegal;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// Immediate formats
	assign imm_i = {{52{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{51{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
	assign imm_j = {{43{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		illegal     = 1'b0;
		micro_o     = '0;
		micro_o.pc  = pc_i;
		micro_o.op  = OP_ILLEGAL;
		micro_o.fn  = ALU_ADD;
		micro_o.rd  = instr_i[11:7];  // Cleared below where unused
		micro_o.rs1 = instr_i[19:15];
		micro_o.rs2 = instr_i[24:20];
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin // rd only
				micro_o.op  = (opcode == OPC_LUI) ? OP_LUI :
				              (opcode == OPC_AUIPC) ? OP_AUIPC : OP_JAL;
				micro_o.imm = (opcode == OPC_JAL) ? imm_j : imm_u;
				micro_o.rs1 = 5'd0;
				micro_o.rs2 = 5'd0;
			end
			OPC_JALR: begin
				micro_o.op  = OP_JALR;
				micro_o.imm = imm_i;
				micro_o.rs2 = 5'd0;
				illegal     = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				micro_o.op  = OP_BRANCH;
				micro_o.imm = imm_b;
				micro_o.rd  = 5'd0;
				case (funct3)
					3'b000: micro_o.fn = ALU_BEQ;
					3'b001: micro_o.fn = ALU_BNE;
					3'b100: micro_o.fn = ALU_BLT;
					3'b101: micro_o.fn = ALU_BGE;
					3'b110: micro_o.fn = ALU_BLTU;
					3'b111: micro_o.fn = ALU_BGEU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				micro_o.op  = OP_LOAD;
				micro_o.fn  = alu_fn_t'({1'b0, funct3}); // Width and sign
				micro_o.imm = imm_i;
				micro_o.rs2 = 5'd0;
				illegal     = (funct3 == 3'b111);
			end
			OPC_STORE: begin
				micro_o.op  = OP_STORE;
				micro_o.fn  = alu_fn_t'({1'b0, funct3});
				micro_o.imm = imm_s;
				micro_o.rd  = 5'd0;
				illegal     = funct3[2]; // SB..SD only
			end
			OPC_OP_IMM, OPC_OP_IMM_32: begin
				micro_o.op      = OP_ALU_IMM;
				micro_o.fn      = alu_fn_t'({1'b0, funct3});
				micro_o.imm     = imm_i;
				micro_o.rs2     = 5'd0;
				micro_o.is_word = (opcode == OPC_OP_IMM_32);
				if (funct3[1:0] == 2'b01) begin // Shifts carry shamt only
					micro_o.imm = micro_o.is_word ? {59'b0, instr_i[24:20]}
					                              : {58'b0, instr_i[25:20]};
					micro_o.fn  = (funct3[2] & funct7[5]) ? ALU_SRA : micro_o.fn;
					illegal     = ({funct7[6], funct7[4:1]} != 5'd0) | (~funct3[2] & funct7[5])
					            | (micro_o.is_word & funct7[0]);
				end else begin
					illegal = micro_o.is_word & (funct3 != 3'b000); // ADDIW only
				end
			end
			OPC_OP, OPC_OP_32: begin
				micro_o.op      = OP_ALU;
				micro_o.fn      = alu_fn_t'({funct7[5], funct3});
				micro_o.is_word = (opcode == OPC_OP_32);
				illegal = ({funct7[6], funct7[4:0]} != 6'd0)
				        | (funct7[5] & (funct3 != 3'b000) & (funct3 != 3'b101))
				        | (micro_o.is_word & (funct3 != 3'b000) & (funct3 != 3'b001)
				           & (funct3 != 3'b101));
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			micro_o    = '0;
			micro_o.pc = pc_i;
			micro_o.op = OP_ILLEGAL;
			micro_o.fn = ALU_ADD;
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
	input  logic         fetch_valid_i,
	output logic         fetch_ready_o,
	input  fetch_pkt_t   fetch_pkt_i,

	input  logic         instr_reject_i, // Queue full
	output logic         instr_push_o,
	output micro_instr_t decoded_uop_o,

	input  logic         flush_i,
	input  logic         CLK,
	input  logic         reset_i
);

	logic         bp_valid;    // Packet available to decode
	logic         bp_ready;    // Buffer can take a packet
	fetch_pkt_t   id_pkt;      // Packet at decode
	micro_instr_t uop_16;
	micro_instr_t uop_32;

	// Buffer absorbs one packet while the queue rejects
	assign fetch_ready_o = bp_ready;

	bypass_fifo #(
		.payload_t(fetch_pkt_t)
	) bp_fifo_i (
		.valid_i (fetch_valid_i),
		.data_i  (fetch_pkt_i),
		.ready_o (bp_ready),
		.valid_o (bp_valid),
		.data_o  (id_pkt),
		.ready_i (~instr_reject_i), // Drains when queue has room
		.flush_i (flush_i),
		.CLK     (CLK),
		.reset_i (reset_i)
	);

	// Both decoders see the same buffered packet
	rvc_decoder rvc_dec_i (
		.instr_i (id_pkt.instr[15:0]),
		.pc_i    (id_pkt.pc),
		.micro_o (uop_16)
	);

	rv_decoder rv_dec_i (
		.instr_i (id_pkt.instr),
		.pc_i    (id_pkt.pc),
		.micro_o (uop_32)
	);

	assign decoded_uop_o = id_pkt.is_rvc ? uop_16 : uop_32;
	assign instr_push_o  = bp_valid & ~instr_reject_i; // Queue has room

endmodule

// ==== logic/instr_fifo.sv ====
`timescale 1ns/1ps

module instr_fifo #(
	parameter type payload_t  = logic,
	parameter int  FIFO_DEPTH = 4 // Power of two, 2 or more
) (
	input  logic     push_i,
	input  payload_t data_i,
	output logic     reject_o, // Full

	output logic     valid_o,
	output payload_t data_o,
	input  logic     ready_i,

	input  logic     flush_i,
	input  logic     CLK,
	input  logic     reset_i
);

	localparam int AW = $clog2(FIFO_DEPTH);

	payload_t      mem [FIFO_DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [AW:0]   count; // One extra bit to hold FIFO_DEPTH
	logic          pop;

	assign reject_o = (count == (AW+1)'(FIFO_DEPTH));
	assign valid_o  = (count != '0);
	assign data_o   = mem[rd_ptr]; // Head entry
	assign pop      = valid_o & ready_i;

	always_ff @(posedge CLK) begin
		if (reset_i | flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			if (pop)    rd_ptr <= rd_ptr + 1'b1;
			case ({push_i, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Push is already qualified by reject upstream
	always_ff @(posedge CLK) begin
		if (push_i & ~flush_i) begin
			mem[wr_ptr] <= data_i;
		end
	end

endmodule

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps

module decode_top import decode_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic         fetch_valid_i,
	output logic         fetch_ready_o,
	input  fetch_pkt_t   fetch_pkt_i,

	output logic         issue_valid_o,
	input  logic         issue_ready_i,
	output micro_instr_t issue_uop_o,

	input  logic         flush_i,
	input  logic         CLK,
	input  logic         reset_i
);

	logic         instr_reject; // Queue to decode
	logic         instr_push;   // Decode to queue
	micro_instr_t decoded_uop;

	decode_stage decode_stage_i (
		.fetch_valid_i  (fetch_valid_i),
		.fetch_ready_o  (fetch_ready_o),
		.fetch_pkt_i    (fetch_pkt_i),
		.instr_reject_i (instr_reject),
		.instr_push_o   (instr_push),
		.decoded_uop_o  (decoded_uop),
		.flush_i        (flush_i),
		.CLK            (CLK),
		.reset_i        (reset_i)
	);

	instr_fifo #(
		.payload_t  (micro_instr_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) instr_fifo_i (
		.push_i   (instr_push),
		.data_i   (decoded_uop),
		.reject_o (instr_reject),
		.valid_o  (issue_valid_o),
		.data_o   (issue_uop_o),
		.ready_i  (issue_ready_i),
		.flush_i  (flush_i),
		.CLK      (CLK),
		.reset_i  (reset_i)
	);

endmodule

// ==== tb/decode_sva.sv ====
`timescale 1ns/1ps

module decode_sva #(
	parameter int W = 1
) (
	input logic         CLK,
	input logic         reset_i,
	input logic         flush_i,
	input logic         push_i,
	input logic         reject_o,
	input logic         valid_o,
	input logic         ready_i,
	input logic [W-1:0] data_o
);

	// Full queue must never see a write
	a_no_push_full: assert property (@(posedge CLK) disable iff (reset_i)
		push_i |-> !reject_o)
		else $error("push while queue full");

	// Stalled head stays put
	a_issue_hold: assert property (@(posedge CLK) disable iff (reset_i)
		valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o))
		else $error("issue entry dropped or changed while stalled");

	a_reset_empty: assert property (@(posedge CLK) reset_i |=> !valid_o)
		else $error("issue valid after reset");

endmodule

// ==== tb/tb_decode.sv ====
`timescale 1ns/1ps

module tb_decode import decode_pkg::*; ();

	localparam int DEPTH   = 4;
	localparam int N_PKTS  = 200 + 200 + 9 + 7 + 150 + (DEPTH + 1) + 40; // All packets sent
	localparam int TIMEOUT = (N_PKTS * 20 + 8) * 4; // ns

	logic         CLK, reset_i, flush_i;
	logic         fetch_valid_i, fetch_ready_o;
	fetch_pkt_t   fetch_pkt_i;
	logic         issue_valid_o, issue_ready_i;
	micro_instr_t issue_uop_o;

	integer       seed = 32'h34397257;
	int           ready_mode; // 0 always ready, 1 random, 2 stalled
	micro_instr_t exp_q [$];  // Expected issue order
	micro_instr_t head;

	decode_top #(.FIFO_DEPTH(DEPTH)) dut_i (.*);

	bind instr_fifo decode_sva #(.W($bits(payload_t))) sva_i (
		.CLK(CLK), .reset_i(reset_i), .flush_i(flush_i), .push_i(push_i),
		.reject_o(reject_o), .valid_o(valid_o), .ready_i(ready_i), .data_o(data_o)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog expired before all packets were issued");
		$display(">>> FAIL");
		$fatal(1);
	end

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic compare_uop(input micro_instr_t e, input micro_instr_t a);
		check_value("pc", e.pc, a.pc);
		check_value("op", e.op, a.op);
		check_value("fn", e.fn, a.fn);
		check_value("rd", e.rd, a.rd);
		check_value("rs1", e.rs1, a.rs1);
		check_value("rs2", e.rs2, a.rs2);
		check_value("imm", e.imm, a.imm);
		check_value("is_word", e.is_word, a.is_word);
		check_value("is_rvc", e.is_rvc, a.is_rvc);
	endtask

	// Expected expansion of a compressed instruction
	function automatic micro_instr_t ref_rvc(input logic [15:0] c, input logic [63:0] pc);
		micro_instr_t u;
		logic [11:0]  o;
		logic [4:0]   rp1, rp2;
		logic         bad;
		u        = '0;
		u.pc     = pc;
		u.is_rvc = 1'b1;
		u.op     = OP_ALU_IMM;
		u.fn     = ALU_ADD;
		bad = 1'b0;
		o   = '0;
		rp1 = 5'd8 + {2'b00, c[9:7]};
		rp2 = 5'd8 + {2'b00, c[4:2]};
		case ({c[1:0], c[15:13]})
			5'b00010, 5'b00110: begin // Word load and store
				u.op  = c[15] ? OP_STORE : OP_LOAD;
				u.fn  = alu_fn_t'(4'd2);
				u.rs1 = rp1;
				if (c[15]) u.rs2 = rp2;
				else u.rd = rp2;
				u.imm = (64'(c[12:10]) << 3) | (64'(c[6]) << 2) | (64'(c[5]) << 6);
			end
			5'b01000, 5'b01001, 5'b01010: begin // ADDI, ADDIW, LI
				u.rd      = c[11:7];
				u.rs1     = (c[14]) ? 5'd0 : c[11:7];
				u.imm     = 64'($signed({c[12], c[6:2]}));
				u.is_word = c[13];
				bad       = c[13] && c[11:7] == 5'd0;
			end
			5'b01101: begin
				u.op    = OP_JAL;
				o[11]   = c[12];
				o[4]    = c[11];
				o[9:8]  = c[10:9];
				o[10]   = c[8];
				o[6]    = c[7];
				o[7]    = c[6];
				o[3:1]  = c[5:3];
				o[5]    = c[2];
				u.imm   = 64'($signed(o));
			end
			5'b01110, 5'b01111: begin
				u.op   = OP_BRANCH;
				u.fn   = c[13] ? ALU_BNE : ALU_BEQ;
				u.rs1  = rp1;
				o[8]   = c[12];
				o[4:3] = c[11:10];
				o[7:6] = c[6:5];
				o[2:1] = c[4:3];
				o[5]   = c[2];
				u.imm  = 64'($signed(o[8:0]));
			end
			5'b10100: begin
				if (c[6:2] != 5'd0) begin // MV or ADD
					u.op  = OP_ALU;
					u.rd  = c[11:7];
					u.rs1 = c[12] ? c[11:7] : 5'd0;
					u.rs2 = c[6:2];
				end else begin // Only JR with rs1 nonzero is legal
					u.op  = OP_JALR;
					u.rs1 = c[11:7];
					bad   = c[12] || c[11:7] == 5'd0;
				end
			end
			default: bad = 1'b1;
		endcase
		if (bad) begin
			u        = '0;
			u.pc     = pc;
			u.is_rvc = 1'b1;
			u.op     = OP_ILLEGAL;
			u.fn     = ALU_ADD;
		end
		return u;
	endfunction

	// Expected decode of a 32-bit RV64I word
	function automatic micro_instr_t ref_rv(input logic [31:0] i, input logic [63:0] pc);
		micro_instr_t u;
		logic [2:0]   f3;
		logic [12:0]  b;
		logic [20:0]  j;
		logic         w, bad;
		u    = '0;
		u.pc = pc;
		u.fn = ALU_ADD;
		f3 = i[14:12];
		w  = i[3]; // Set for the W opcodes
		bad = 1'b0;
		b = {i[31], i[7], i[30:25], i[11:8], 1'b0};
		j = {i[31], i[19:12], i[20], i[30:21], 1'b0};
		case (i[6:0])
			7'h37, 7'h17: begin
				u.op  = i[5] ? OP_LUI : OP_AUIPC;
				u.rd  = i[11:7];
				u.imm = 64'($signed({i[31:12], 12'h000}));
			end
			7'h6f: begin
				u.op  = OP_JAL;
				u.rd  = i[11:7];
				u.imm = 64'($signed(j));
			end
			7'h67: begin
				u.op  = OP_JALR;
				u.rd  = i[11:7];
				u.rs1 = i[19:15];
				u.imm = 64'($signed(i[31:20]));
				bad   = f3 != 3'd0;
			end
			7'h63: begin
				u.op  = OP_BRANCH;
				u.rs1 = i[19:15];
				u.rs2 = i[24:20];
				u.imm = 64'($signed(b));
				case (f3)
					3'd0: u.fn = ALU_BEQ;
					3'd1: u.fn = ALU_BNE;
					3'd4: u.fn = ALU_BLT;
					3'd5: u.fn = ALU_BGE;
					3'd6: u.fn = ALU_BLTU;
					3'd7: u.fn = ALU_BGEU;
					default: bad = 1'b1;
				endcase
			end
			7'h03: begin
				u.op  = OP_LOAD;
				u.rd  = i[11:7];
				u.rs1 = i[19:15];
				u.fn  = alu_fn_t'({1'b0, f3});
				u.imm = 64'($signed(i[31:20]));
				bad   = f3 == 3'd7; // No LDU
			end
			7'h23: begin
				u.op  = OP_STORE;
				u.rs1 = i[19:15];
				u.rs2 = i[24:20];
				u.fn  = alu_fn_t'({1'b0, f3});
				u.imm = 64'($signed({i[31:25], i[11:7]}));
				bad   = f3 > 3'd3;
			end
			7'h13, 7'h1b: begin
				u.op      = OP_ALU_IMM;
				u.rd      = i[11:7];
				u.rs1     = i[19:15];
				u.is_word = w;
				u.fn      = alu_fn_t'({1'b0, f3});
				u.imm     = 64'($signed(i[31:20]));
				if (f3 == 3'd1 || f3 == 3'd5) begin
					u.imm = w ? 64'(i[24:20]) : 64'(i[25:20]);
					if (f3 == 3'd5 && i[30]) u.fn = ALU_SRA;
					bad = (i[31:26] != 6'b000000 && !(i[31:26] == 6'b010000 && f3 == 3'd5))
						|| (w && i[25]);
				end else begin
					bad = w && f3 != 3'd0;
				end
			end
			7'h33, 7'h3b: begin
				u.op      = OP_ALU;
				u.rd      = i[11:7];
				u.rs1     = i[19:15];
				u.rs2     = i[24:20];
				u.is_word = w;
				u.fn = alu_fn_t'({1'b0, f3});
				if (i[31:25] == 7'h20) u.fn = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
				bad = !(i[31:25] == 7'h00 || (i[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
					|| (w && !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5));
			end
			default: bad = 1'b1;
		endcase
		if (bad) begin
			u    = '0;
			u.pc = pc;
			u.op = OP_ILLEGAL;
			u.fn = ALU_ADD;
		end
		return u;
	endfunction

	function automatic micro_instr_t ref_decode(input fetch_pkt_t p);
		return p.is_rvc ? ref_rvc(p.instr[15:0], p.pc) : ref_rv(p.instr, p.pc);
	endfunction

	// Legal RV64I word from one of the opcode templates
	function automatic logic [31:0] rand_rv();
		logic [31:0] i;
		logic [6:0]  opc;
		i = $random(seed);
		case (($random(seed) & 32'h7fff_ffff) % 11)
			0: opc = OPC_LUI;
			1: opc = OPC_AUIPC;
			2: opc = OPC_JAL;
			3: opc = OPC_JALR;
			4: opc = OPC_BRANCH;
			5: opc = OPC_LOAD;
			6: opc = OPC_STORE;
			7: opc = OPC_OP_IMM;
			8: opc = OPC_OP;
			9: opc = OPC_OP_IMM_32;
			default: opc = OPC_OP_32;
		endcase
		i[6:0] = opc;
		if (opc == OPC_JALR) i[14:12] = 3'd0;
		if (opc == OPC_BRANCH && i[14:13] == 2'b01) i[13] = 1'b0;
		if (opc == OPC_LOAD && i[14:12] == 3'd7) i[14] = 1'b0;
		if (opc == OPC_STORE) i[14] = 1'b0;
		if (opc == OPC_OP_IMM || opc == OPC_OP_IMM_32) begin
			if (i[13:12] == 2'b01) begin // Shift form
				i[31:26] = {1'b0, i[30] & i[14], 4'b0000};
				if (opc == OPC_OP_IMM_32) i[25] = 1'b0;
			end else if (opc == OPC_OP_IMM_32) begin
				i[14:12] = 3'd0;
			end
		end
		if (opc == OPC_OP || opc == OPC_OP_32) begin
			if (opc == OPC_OP_32 && !(i[14:12] inside {3'd0, 3'd1, 3'd5})) i[14:12] = 3'd0;
			i[31:25] = {1'b0, i[30] & (i[14:12] == 3'd0 || i[14:12] == 3'd5), 5'b00000};
		end
		return i;
	endfunction

	// Supported compressed form with random upper halfword
	function automatic logic [31:0] rand_rvc();
		logic [31:0] c;
		c = $random(seed);
		case (($random(seed) & 32'h7fff_ffff) % 9)
			0: {c[15:13], c[1:0]} = 5'b000_01; // ADDI
			1: {c[15:13], c[1:0]} = 5'b001_01; // ADDIW
			2: {c[15:13], c[1:0]} = 5'b010_01; // LI
			3: {c[15:13], c[1:0]} = 5'b101_01; // J
			4: {c[15:13], c[1:0]} = 5'b110_01;
			5: {c[15:13], c[1:0]} = 5'b111_01;
			6: {c[15:13], c[1:0]} = 5'b010_00; // LW
			7: {c[15:13], c[1:0]} = 5'b110_00; // SW
			default: {c[15:13], c[1:0]} = 5'b100_10;
		endcase
		if (c[15:13] == 3'b001 && c[1:0] == 2'b01 && c[11:7] == 5'd0) c[7] = 1'b1;
		if (c[15:13] == 3'b100 && c[1:0] == 2'b10) begin
			if (c[16]) begin // JR
				c[12]  = 1'b0;
				c[6:2] = 5'd0;
				if (c[11:7] == 5'd0) c[7] = 1'b1;
			end else if (c[6:2] == 5'd0) begin
				c[2] = 1'b1;
			end
		end
		return c;
	endfunction

	function automatic fetch_pkt_t make_pkt(input logic [31:0] instr, input logic rvc);
		fetch_pkt_t p;
		p.instr  = instr;
		p.pc     = {$random(seed), $random(seed)} & ~64'h1;
		p.is_rvc = rvc;
		return p;
	endfunction

	// Hold the packet until the handshake completes
	task automatic send(input fetch_pkt_t p);
		fetch_pkt_i   <= p;
		fetch_valid_i <= 1'b1;
		do @(posedge CLK); while (!fetch_ready_o);
		fetch_valid_i <= 1'b0;
	endtask

	always @(posedge CLK) begin
		if (ready_mode == 0) issue_ready_i <= 1'b1;
		else if (ready_mode == 2) issue_ready_i <= 1'b0;
		else if (($random(seed) & 7) == 0) issue_ready_i <= ~issue_ready_i; // Long stretches
	end

	// Scoreboard
	always @(posedge CLK) begin
		if (!reset_i) begin
			if (exp_q.size() == DEPTH + 1) check_value("fetch_ready_o", 64'd0, fetch_ready_o);
			if (flush_i) begin
				exp_q.delete(); // Pending work is dropped
			end else begin
				if (issue_valid_o && issue_ready_i) begin
					if (exp_q.size() == 0) begin
						$display("Issue transfer at %0t ns with nothing expected", $time);
						$display(">>> FAIL");
						$fatal(1);
					end
					head = exp_q.pop_front();
					compare_uop(head, issue_uop_o);
				end
				if (fetch_valid_i && fetch_ready_o) exp_q.push_back(ref_decode(fetch_pkt_i));
			end
		end
	end

	initial begin
		logic [31:0]  bad_rv [9];
		logic [15:0]  bad_rvc [7];
		micro_instr_t ill_uop;
		logic         rvc_sel;
		bad_rv  = '{32'h0000000f, 32'h00000073, 32'h02a58533, 32'h40a59533, 32'h02a5053b,
			32'h00a5c53b, 32'h0000007f, 32'h40051513, 32'h0000301b};
		bad_rvc = '{16'h0000, 16'h9002, 16'h8002, 16'h2001, 16'h6000, 16'hffff, 16'he002};
		reset_i       = 1'b1;
		flush_i       = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_pkt_i   = '0;
		issue_ready_i = 1'b1;
		ready_mode    = 0;
		repeat (8) @(posedge CLK);
		reset_i <= 1'b0;
		@(posedge CLK);
		check_value("issue_valid_o", 64'd0, issue_valid_o);
		check_value("fetch_ready_o", 64'd1, fetch_ready_o);
		repeat (200) send(make_pkt(rand_rv(), 1'b0));
		repeat (200) send(make_pkt(rand_rvc(), 1'b1));
		foreach (bad_rv[k]) begin
			ill_uop = ref_rv(bad_rv[k], 64'd0);
			check_value("illegal template class", OP_ILLEGAL, ill_uop.op);
			send(make_pkt(bad_rv[k], 1'b0));
		end
		foreach (bad_rvc[k]) begin
			ill_uop = ref_rvc(bad_rvc[k], 64'd0);
			check_value("illegal template class", OP_ILLEGAL, ill_uop.op);
			send(make_pkt({16'h5a5a, bad_rvc[k]}, 1'b1));
		end
		ready_mode <= 1; // Back-pressure
		repeat (150) begin
			repeat ($random(seed) & 3) @(posedge CLK);
			rvc_sel = $random(seed) & 1;
			send(make_pkt(rvc_sel ? rand_rvc() : rand_rv(), rvc_sel));
		end
		ready_mode <= 0; // Drain before the flush test
		while (exp_q.size() != 0) @(posedge CLK);
		ready_mode <= 2; // Fill both buffers and flush
		repeat (2) @(posedge CLK);
		repeat (DEPTH + 1) send(make_pkt(rand_rv(), 1'b0));
		flush_i <= 1'b1;
		@(posedge CLK);
		flush_i <= 1'b0;
		repeat (3) begin
			@(posedge CLK);
			check_value("issue_valid_o", 64'd0, issue_valid_o);
		end
		ready_mode <= 0;
		repeat (40) send(make_pkt(rand_rvc(), 1'b1));
		while (exp_q.size() != 0) @(posedge CLK);
		repeat (4) @(posedge CLK);
		if (exp_q.size() != 0 || issue_valid_o) begin
			$display("Queue not drained at end of run");
			$display(">>> FAIL");
			$fatal(1);
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
logic/decode_pkg.sv
logic/bypass_fifo.sv
logic/rvc_decoder.sv
logic/rv_decoder.sv
logic/decode_stage.sv
logic/instr_fifo.sv
logic/decode_top.sv
tb/decode_sva.sv
tb/tb_decode.sv

// ==== Makefile ====
TOP := tb_decode

all: run

obj_dir/V$(TOP): sources.f $(wildcard logic/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
